/* build.f */
src/axi_rd_pkg.sv
src/conv_rd_pkg.sv
src/axis_reg_slice.sv
src/burst_splitter.sv
src/burst_tracker.sv
src/byte_realigner.sv
src/axi_rchn_conv_in.sv
verif/tb_axi_rchn_conv_in.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_axi_rchn_conv_in
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* verif/tb_axi_rchn_conv_in.sv */
`timescale 1ns/100ps

module tb_axi_rchn_conv_in
	import axi_rd_pkg::*;
	import conv_rd_pkg::*;
#(
	parameter int max_rd_btt      = 2048,
	parameter int max_burst_len   = 32,
	parameter int max_outstanding = 4
) ();

	localparam logic [31:0] seed = 32'h622e;
	localparam int num_req        = 40;
	localparam int timeout_cycles = 200 * num_req + 2000;

	logic         clk = 1'b0;
	logic         rst_n;
	rd_req_t      rd_req_i;
	logic         rd_req_valid_i;
	logic         rd_req_ready_o;
	ar_req_t      m_axi_ar_o;
	logic         m_axi_arvalid_o;
	logic         m_axi_arready_i;
	r_beat_t      m_axi_r_i;
	logic         m_axi_rvalid_i;
	logic         m_axi_rready_o;
	stream_beat_t ft_par_o;
	logic         ft_par_valid_o;
	logic         ft_par_ready_i;

	logic [31:0] lcg_state = seed;
	logic [7:0]  exp_q [$];      // expected output bytes in order
	int          out_len_q [$];  // byte count per accepted request
	axi_addr_t   ar_start_q [$]; // first beat address per request
	int          ar_beats_q [$]; // beats each request must cover
	ar_req_t     mem_ar_q [$];   // bursts waiting for read data
	axi_addr_t   ar_addr = '0;   // next expected AR address
	int          ar_left = 0;
	int          out_left = 0;
	int          outstanding = 0;
	int          done_cnt = 0;
	int          errors = 0;
	logic        accept_seen = 1'b0;

	axi_rchn_conv_in #(
		.max_rd_btt      (max_rd_btt),
		.max_burst_len   (max_burst_len),
		.max_outstanding (max_outstanding)
	) axi_rchn_conv_in_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.rd_req_i        (rd_req_i),
		.rd_req_valid_i  (rd_req_valid_i),
		.rd_req_ready_o  (rd_req_ready_o),
		.m_axi_ar_o      (m_axi_ar_o),
		.m_axi_arvalid_o (m_axi_arvalid_o),
		.m_axi_arready_i (m_axi_arready_i),
		.m_axi_r_i       (m_axi_r_i),
		.m_axi_rvalid_i  (m_axi_rvalid_i),
		.m_axi_rready_o  (m_axi_rready_o),
		.ft_par_o        (ft_par_o),
		.ft_par_valid_o  (ft_par_valid_o),
		.ft_par_ready_i  (ft_par_ready_i)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		lcg_state = lcg(lcg_state);
		r = lcg_state;
	endtask

	// memory contents, also the reference for every expected byte
	function automatic logic [7:0] mem_byte(input axi_addr_t a);
		return a[7:0] ^ a[15:8];
	endfunction

	function automatic axi_data_t beat_data(input axi_addr_t a);
		axi_data_t d;
		for (int k = 0; k < beat_bytes; k++)
			d[k*8 +: 8] = mem_byte(a + axi_addr_t'(k));
		return d;
	endfunction

	task automatic check_equal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			errors++;
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run aborted");
	endtask

	task automatic record_request(input rd_req_t req);
		int off;
		off = int'(req.addr[2:0]);
		ar_start_q.push_back({req.addr[31:3], 3'b000});
		ar_beats_q.push_back((off + int'(req.btt) + beat_bytes - 1) / beat_bytes);
		out_len_q.push_back(int'(req.btt));
		for (int j = 0; j < int'(req.btt); j++)
			exp_q.push_back(mem_byte(req.addr + axi_addr_t'(j)));
	endtask

	task automatic check_burst(input ar_req_t ar);
		int beats;
		beats = int'(ar.len) + 1;
		if (ar_left == 0)
		begin
			if (ar_start_q.size() == 0)
				abort_run("An AR burst was issued while no request was pending");
			else
			begin
				ar_addr = ar_start_q.pop_front();
				ar_left = ar_beats_q.pop_front();
			end
		end
		check_equal(64'(ar.addr[2:0]), 64'd0, "AR alignment");
		check_equal(64'(ar.addr), 64'(ar_addr), "AR address");
		check_equal(64'(beats <= max_burst_len), 64'd1, "AR burst length limit");
		check_equal(64'(beats <= ar_left), 64'd1, "AR burst past request end");
		check_equal(64'(int'(ar.addr[11:3]) + beats <= page_beats), 64'd1, "AR 4 KB crossing");
		ar_addr = ar_addr + axi_addr_t'(beats * beat_bytes);
		ar_left -= beats;
		outstanding++;
		check_equal(64'(outstanding <= max_outstanding), 64'd1, "outstanding bursts");
		mem_ar_q.push_back(ar);
	endtask

	task automatic check_output(input stream_beat_t b);
		int         n;
		byte_keep_t exp_keep;
		if (out_left == 0)
		begin
			if (out_len_q.size() == 0)
				abort_run("An output beat arrived while no request was outstanding");
			else
				out_left = out_len_q.pop_front();
		end
		n = (out_left < beat_bytes) ? out_left : beat_bytes;
		exp_keep = byte_keep_t'((16'd1 << n) - 16'd1); // low n lanes
		check_equal(64'(b.keep), 64'(exp_keep), "output keep");
		check_equal(64'(b.last), 64'(out_left == n), "output last");
		for (int k = 0; k < n; k++)
			check_equal(64'(b.data[k*8 +: 8]), 64'(exp_q.pop_front()), "output byte");
		out_left -= n;
		if (out_left == 0)
			done_cnt++;
	endtask

	// bus monitor and scoreboard, sampled on the edge before inputs move
	always @(posedge clk)
	begin
		if (rst_n)
		begin
			if (accept_seen)
				check_equal(64'(rd_req_ready_o), 64'd0, "request ready after accept");
			accept_seen = rd_req_valid_i & rd_req_ready_o;
			if (accept_seen)
				record_request(rd_req_i);
			if (m_axi_rvalid_i & m_axi_rready_o & m_axi_r_i.last)
				outstanding--;
			if (m_axi_arvalid_o & m_axi_arready_i)
				check_burst(m_axi_ar_o);
			if (ft_par_valid_o & ft_par_ready_i)
				check_output(ft_par_o);
		end
	end

	// memory model, beats returned in AR order
	initial
	begin
		ar_req_t     cur;
		int          beat;
		logic        fired;
		logic [31:0] r;
		m_axi_rvalid_i = 1'b0;
		m_axi_r_i      = '0;
		beat           = 0;
		forever
		begin
			@(posedge clk);
			fired = m_axi_rvalid_i & m_axi_rready_o;
			#1;
			if (fired)
			begin
				if (m_axi_r_i.last)
				begin
					void'(mem_ar_q.pop_front());
					beat = 0;
				end
				else
					beat++;
			end
			if (fired | ~m_axi_rvalid_i) // valid holds until taken
			begin
				next_rand(r);
				if (mem_ar_q.size() != 0 && r[31:29] != 3'd0)
				begin
					cur              = mem_ar_q[0];
					m_axi_r_i.data   = beat_data(cur.addr + axi_addr_t'(beat * beat_bytes));
					m_axi_r_i.last   = (beat == int'(cur.len));
					m_axi_rvalid_i   = 1'b1;
				end
				else
					m_axi_rvalid_i = 1'b0;
			end
		end
	end

	// random stalls on arready and output ready
	initial
	begin
		logic [31:0] r;
		m_axi_arready_i = 1'b0;
		ft_par_ready_i  = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			next_rand(r);
			m_axi_arready_i = (r[31:30] != 2'd0);
			ft_par_ready_i  = (r[28:26] != 3'd0);
		end
	end

	initial
	begin
		repeat (timeout_cycles) @(posedge clk);
		abort_run($sformatf("Timeout: the run did not finish within %0d cycles", timeout_cycles));
	end

	initial
	begin
		logic [31:0] r;
		rd_req_t     req;
		rst_n          = 1'b0;
		rd_req_valid_i = 1'b0;
		rd_req_i       = '0;
		repeat (4) @(posedge clk);
		#1 rst_n = 1'b1;
		@(posedge clk);
		check_equal(64'(rd_req_ready_o), 64'd1, "request ready after reset");
		check_equal(64'(m_axi_arvalid_o), 64'd0, "AR valid after reset");
		check_equal(64'(ft_par_valid_o), 64'd0, "output valid after reset");
		#1;
		for (int i = 0; i < num_req; i++)
		begin
			next_rand(r);
			req.btt = (r >> 8) % 32'(max_rd_btt) + 32'd1;
			next_rand(r);
			if (r[31:30] == 2'd0)
				req.addr = {4'h0, r[29:15], 1'b1, 12'h000} - 32'(r[11:6]) - 32'd1; // just below 4 KB
			else
				req.addr = {4'h0, r[29:2]};
			rd_req_i       = req;
			rd_req_valid_i = 1'b1;
			do
				@(posedge clk);
			while (!rd_req_ready_o);
			#1 rd_req_valid_i = 1'b0;
			next_rand(r);
			repeat (int'(r[31:30]))
			begin
				@(posedge clk);
				#1;
			end
		end
		while (done_cnt < num_req)
			@(posedge clk);
		repeat (10) @(posedge clk);
		// everything drained, the DUT sits idle
		check_equal(64'(rd_req_ready_o), 64'd1, "request ready when idle");
		check_equal(64'(m_axi_arvalid_o), 64'd0, "AR valid when idle");
		check_equal(64'(ft_par_valid_o), 64'd0, "output valid when idle");
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

/* src/axi_rchn_conv_in.sv */
`timescale 1ns/100ps

module axi_rchn_conv_in
	import axi_rd_pkg::*;
	import conv_rd_pkg::*;
#(
	parameter int max_rd_btt      = 2048,
	parameter int max_burst_len   = 32,
	parameter int max_outstanding = 4
) (
	input  logic         clk,
	input  logic         rst_n,

	input  rd_req_t      rd_req_i,
	input  logic         rd_req_valid_i,
	output logic         rd_req_ready_o,

	output ar_req_t      m_axi_ar_o,
	output logic         m_axi_arvalid_o,
	input  logic         m_axi_arready_i,

	input  r_beat_t      m_axi_r_i,
	input  logic         m_axi_rvalid_i,
	output logic         m_axi_rready_o,

	output stream_beat_t ft_par_o,
	output logic         ft_par_valid_o,
	input  logic         ft_par_ready_i
);

	ar_req_t      spl_ar;
	logic         spl_ar_valid;
	logic         spl_ar_ready;
	logic         ar_allow;
	logic         burst_issued;
	burst_info_t  burst_info;
	stream_beat_t trk_beat;  // tagged R beat
	logic         trk_valid;
	logic         trk_ready;
	stream_beat_t rlg_beat;  // realigned beat
	logic         rlg_valid;
	logic         rlg_ready;

	burst_splitter #(
		.max_rd_btt    (max_rd_btt),
		.max_burst_len (max_burst_len)
	) burst_splitter_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.req_i          (rd_req_i),
		.req_valid_i    (rd_req_valid_i),
		.req_ready_o    (rd_req_ready_o),
		.ar_o           (spl_ar),
		.ar_valid_o     (spl_ar_valid),
		.ar_ready_i     (spl_ar_ready),
		.ar_allow_i     (ar_allow),
		.burst_issued_o (burst_issued),
		.burst_info_o   (burst_info)
	);

	axis_reg_slice #(
		.payload_t (ar_req_t)
	) ar_slice_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.s_data_i  (spl_ar),
		.s_valid_i (spl_ar_valid),
		.s_ready_o (spl_ar_ready),
		.m_data_o  (m_axi_ar_o),
		.m_valid_o (m_axi_arvalid_o),
		.m_ready_i (m_axi_arready_i)
	);

	burst_tracker #(
		.max_outstanding (max_outstanding)
	) burst_tracker_i (
		.clk            (clk),
		.rst_n          (rst_n),
		.burst_issued_i (burst_issued),
		.burst_info_i   (burst_info),
		.ar_allow_o     (ar_allow),
		.r_i            (m_axi_r_i),
		.r_valid_i      (m_axi_rvalid_i),
		.r_ready_o      (m_axi_rready_o),
		.beat_o         (trk_beat),
		.beat_valid_o   (trk_valid),
		.beat_ready_i   (trk_ready)
	);

	byte_realigner byte_realigner_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.beat_i       (trk_beat),
		.beat_valid_i (trk_valid),
		.beat_ready_o (trk_ready),
		.beat_o       (rlg_beat),
		.beat_valid_o (rlg_valid),
		.beat_ready_i (rlg_ready)
	);

	axis_reg_slice #(
		.payload_t (stream_beat_t)
	) out_slice_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.s_data_i  (rlg_beat),
		.s_valid_i (rlg_valid),
		.s_ready_o (rlg_ready),
		.m_data_o  (ft_par_o),
		.m_valid_o (ft_par_valid_o),
		.m_ready_i (ft_par_ready_i)
	);

endmodule

/* src/byte_realigner.sv */
`timescale 1ns/100ps

module byte_realigner
	import axi_rd_pkg::*;
	import conv_rd_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  stream_beat_t beat_i,
	input  logic         beat_valid_i,
	output logic         beat_ready_o,

	output stream_beat_t beat_o,
	output logic         beat_valid_o,
	input  logic         beat_ready_i
);

	logic       first_q;      // next input beat opens a packet
	logic       flush_q;      // leftover bytes still held in buf
	byte_idx_t  shift_q;      // empty low lanes of the first beat
	byte_keep_t first_keep_q;
	byte_keep_t flush_mask_q; // lanes that come from buf alone
	axi_data_t  buf_data_q;   // previous input beat
	byte_keep_t buf_keep_q;

	byte_idx_t  shift_nxt;
	logic       in_fire;
	logic       one_beat;
	logic       tail_left;
	logic [5:0] lo_sh;
	logic [6:0] hi_sh;
	logic [3:0] keep_sh;
	axi_data_t  merged_data;
	byte_keep_t merged_keep;

	assign shift_nxt = low_empty_lanes(beat_i.keep);
	assign in_fire   = beat_valid_i & beat_ready_o;
	assign one_beat  = first_q & beat_i.last & ~flush_q;
	// last beat still has bytes above the shift point
	assign tail_left = |(beat_i.keep & first_keep_q);

	assign lo_sh   = {shift_q, 3'b000};
	assign hi_sh   = 7'(beat_bytes * 8) - {1'b0, lo_sh};
	assign keep_sh = 4'(beat_bytes) - {1'b0, shift_q};

	// upper bytes of buf into the low lanes, low bytes of the new beat above them
	assign merged_data = (buf_data_q >> lo_sh) | (beat_i.data << hi_sh);
	assign merged_keep = (buf_keep_q >> shift_q) | (beat_i.keep << keep_sh);

	assign beat_ready_o = ~flush_q & beat_ready_i;
	// a packet's first beat only fills buf
	assign beat_valid_o = flush_q | (beat_valid_i & ~(first_q & ~beat_i.last));

	always_comb
	begin
		if (one_beat)
		begin
			beat_o.data = beat_i.data >> {shift_nxt, 3'b000};
			beat_o.keep = beat_i.keep >> shift_nxt;
		end
		else if (flush_q)
		begin
			beat_o.data = merged_data;
			beat_o.keep = merged_keep & flush_mask_q; // input beat belongs to the next packet
		end
		else
		begin
			beat_o.data = merged_data;
			beat_o.keep = merged_keep;
		end
		beat_o.last = flush_q | (beat_i.last & (first_q | ~tail_left));
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			first_q <= 1'b1;
			flush_q <= 1'b0;
		end
		else
		begin
			if (in_fire)
				first_q <= beat_i.last;
			if (flush_q)
				flush_q <= ~beat_ready_i;
			else
				flush_q <= in_fire & ~first_q & beat_i.last & tail_left;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_fire & first_q)
		begin
			shift_q      <= shift_nxt;
			first_keep_q <= beat_i.keep;
			flush_mask_q <= keep_upto(~shift_nxt);
		end
		if (in_fire)
		begin
			buf_data_q <= beat_i.data;
			buf_keep_q <= beat_i.keep;
		end
	end

endmodule

/* src/burst_tracker.sv */
`timescale 1ns/100ps

module burst_tracker
	import axi_rd_pkg::*;
	import conv_rd_pkg::*;
#(
	parameter int max_outstanding = 4
) (
	input  logic         clk,
	input  logic         rst_n,

	input  logic         burst_issued_i,
	input  burst_info_t  burst_info_i,
	output logic         ar_allow_o,

	input  r_beat_t      r_i,
	input  logic         r_valid_i,
	output logic         r_ready_o,

	output stream_beat_t beat_o,
	output logic         beat_valid_o,
	input  logic         beat_ready_i
);

	localparam int cnt_w = $clog2(max_outstanding + 1);

	logic [cnt_w-1:0]           count_q; // bursts in flight
	logic                       full_q;
	logic [max_outstanding-1:0] wptr_q;  // one-hot
	logic [max_outstanding-1:0] rptr_q;  // one-hot
	burst_info_t                info_q [max_outstanding];
	burst_info_t                head;
	logic                       first_q; // next beat opens a packet
	logic                       burst_done;
	logic                       pkt_last;

	assign burst_done = r_valid_i & r_ready_o & r_i.last;
	assign ar_allow_o = ~full_q;

	always_comb
	begin
		head = info_q[0];
		for (int i = 0; i < max_outstanding; i++)
			if (rptr_q[i])
				head = info_q[i];
	end

	assign pkt_last = r_i.last & head.last_burst;

	assign r_ready_o    = beat_ready_i;
	assign beat_valid_o = r_valid_i;
	assign beat_o.data  = r_i.data;
	assign beat_o.last  = pkt_last;
	// first beat drops the leading lanes, last beat the trailing ones
	assign beat_o.keep  = (first_q ? keep_from(head.first_idx) : '1) &
		(pkt_last ? keep_upto(head.last_idx) : '1);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			count_q <= '0;
			full_q  <= 1'b0;
			wptr_q  <= max_outstanding'(1);
			rptr_q  <= max_outstanding'(1);
			first_q <= 1'b1;
		end
		else
		begin
			if (burst_issued_i ^ burst_done)
			begin
				count_q <= burst_issued_i ? count_q + 1'b1 : count_q - 1'b1;
				full_q  <= burst_issued_i & (count_q == cnt_w'(max_outstanding - 1));
			end
			if (burst_issued_i)
				wptr_q <= (wptr_q << 1) | (wptr_q >> (max_outstanding - 1));
			if (burst_done)
				rptr_q <= (rptr_q << 1) | (rptr_q >> (max_outstanding - 1));
			if (r_valid_i & r_ready_o)
				first_q <= pkt_last;
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < max_outstanding; i++)
			if (burst_issued_i & wptr_q[i])
				info_q[i] <= burst_info_i;
	end

endmodule

/* src/burst_splitter.sv */
`timescale 1ns/100ps

module burst_splitter
	import axi_rd_pkg::*;
	import conv_rd_pkg::*;
#(
	parameter int max_rd_btt    = 2048,
	parameter int max_burst_len = 32
) (
	input  logic        clk,
	input  logic        rst_n,

	input  rd_req_t     req_i,
	input  logic        req_valid_i,
	output logic        req_ready_o,

	output ar_req_t     ar_o,
	output logic        ar_valid_o,
	input  logic        ar_ready_i,
	input  logic        ar_allow_i,

	output logic        burst_issued_o,
	output burst_info_t burst_info_o
);

	localparam int btt_w  = $clog2(max_rd_btt + 1);
	localparam int end_w  = $clog2(max_rd_btt + beat_bytes); // offset + byte count
	localparam int beat_w = end_w - 2;
	localparam int len_w  = $clog2(page_beats) + 1;          // holds 1..page_beats
	localparam int cmp_w  = (beat_w > len_w) ? beat_w : len_w;

	logic              req_ready_q;
	logic [btt_w-1:0]  btt;
	logic [end_w-1:0]  end_off;
	axi_addr_t         addr_q;    // beat-aligned address of the next burst
	logic [beat_w-1:0] rem_beats; // beats still to request
	logic [len_w-1:0]  page_left; // beats up to the next 4 KB page
	byte_idx_t         first_idx_q;
	byte_idx_t         last_idx_q;
	logic [len_w-1:0]  lim_beats;
	logic [len_w-1:0]  burst_beats;
	logic              last_burst;
	logic              req_fire;
	logic              ar_fire;

	assign btt     = req_i.btt[btt_w-1:0];
	assign end_off = end_w'(btt) + end_w'(req_i.addr[2:0]);

	assign req_fire = req_valid_i & req_ready_q;
	assign ar_fire  = ar_valid_o & ar_ready_i;

	// min(page room, max burst length)
	assign lim_beats = (page_left < len_w'(max_burst_len)) ? page_left : len_w'(max_burst_len);

	// rest of the request fits in this burst
	assign last_burst  = cmp_w'(rem_beats) <= cmp_w'(lim_beats);
	assign burst_beats = last_burst ? len_w'(rem_beats) : lim_beats;

	assign req_ready_o = req_ready_q;
	assign ar_valid_o  = ~req_ready_q & ar_allow_i;
	assign ar_o.addr   = addr_q;
	assign ar_o.len    = axi_len_t'(burst_beats - len_w'(1));

	assign burst_issued_o          = ar_fire;
	assign burst_info_o.last_burst = last_burst;
	assign burst_info_o.first_idx  = first_idx_q;
	assign burst_info_o.last_idx   = last_idx_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			req_ready_q <= 1'b1;
		else if (req_fire)
			req_ready_q <= 1'b0;
		else if (ar_fire & last_burst)
			req_ready_q <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
		begin
			addr_q      <= {req_i.addr[31:3], 3'b000};
			rem_beats   <= beat_w'(end_off[end_w-1:3]) + beat_w'(end_off[2:0] != 3'd0);
			page_left   <= len_w'(page_beats) - len_w'(req_i.addr[11:3]); // 4 KB page
			first_idx_q <= req_i.addr[2:0];
			last_idx_q  <= end_off[2:0] - 3'd1;
		end
		else if (ar_fire)
		begin
			addr_q    <= addr_q + (axi_addr_t'(burst_beats) << 3);
			rem_beats <= rem_beats - beat_w'(burst_beats);
			// crossing into a new page refills the room
			if (page_left == burst_beats)
				page_left <= len_w'(page_beats);
			else
				page_left <= page_left - burst_beats;
		end
	end

endmodule

/* src/axis_reg_slice.sv */
`timescale 1ns/100ps

module axis_reg_slice #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst_n,

	input  payload_t s_data_i,
	input  logic     s_valid_i,
	output logic     s_ready_o,

	output payload_t m_data_o,
	output logic     m_valid_o,
	input  logic     m_ready_i
);

	payload_t main_q; // entry seen by the sink
	payload_t skid_q; // catches a beat while the sink stalls
	logic     main_valid_q;
	logic     skid_valid_q;
	logic     main_load;

	assign main_load = m_ready_i | ~main_valid_q; // output stage free this cycle
	assign s_ready_o = ~skid_valid_q;              // ready straight from a flop
	assign m_valid_o = main_valid_q;
	assign m_data_o  = main_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			main_valid_q <= 1'b0;
			skid_valid_q <= 1'b0;
		end
		else if (main_load)
		begin
			// skid drains first, input waits while skid is full
			main_valid_q <= skid_valid_q | s_valid_i;
			skid_valid_q <= 1'b0;
		end
		else if (s_valid_i & s_ready_o)
			skid_valid_q <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (main_load & (skid_valid_q | s_valid_i))
			main_q <= skid_valid_q ? skid_q : s_data_i;
		if (~main_load & s_valid_i & s_ready_o)
			skid_q <= s_data_i;
	end

endmodule

/* src/conv_rd_pkg.sv */
package conv_rd_pkg;

	import axi_rd_pkg::*;

	typedef logic [2:0]            byte_idx_t;  // byte lane in a beat
	typedef logic [beat_bytes-1:0] byte_keep_t; // one bit per lane

	// read request from the convolution engine
	typedef struct packed
	{
		logic [31:0] btt;  // bytes to transfer
		axi_addr_t   addr; // base address, may be unaligned
	} rd_req_t;

	// per-burst info, one entry per burst in flight
	typedef struct packed
	{
		logic      last_burst; // final burst of the request
		byte_idx_t first_idx;  // lane of the first requested byte
		byte_idx_t last_idx;   // lane of the last requested byte
	} burst_info_t;

	typedef struct packed
	{
		axi_data_t  data;
		byte_keep_t keep;
		logic       last; // last beat of the packet
	} stream_beat_t;

	// lanes idx and above
	function automatic byte_keep_t keep_from(input byte_idx_t idx);
		byte_keep_t all;
		all = '1;
		return all << idx;
	endfunction

	// lanes 0 up to idx
	function automatic byte_keep_t keep_upto(input byte_idx_t idx);
		byte_keep_t all;
		all = '1;
		return all >> (~idx);
	endfunction

	// number of empty lanes below the first kept one
	function automatic byte_idx_t low_empty_lanes(input byte_keep_t keep);
		byte_idx_t n;
		n = '0;
		for (int i = beat_bytes - 1; i >= 0; i--)
			if (keep[i])
				n = byte_idx_t'(i);
		return n;
	endfunction

endpackage

/* src/axi_rd_pkg.sv */
package axi_rd_pkg;

	// AXI read bus, INCR bursts of 8-byte beats
	localparam int beat_bytes = 8;   // bytes per beat
	localparam int page_beats = 512; // beats in one 4 KB page

	typedef logic [31:0] axi_addr_t; // byte address
	typedef logic [63:0] axi_data_t; // one beat
	typedef logic [7:0]  axi_len_t;  // burst length minus one

	// AR channel payload
	typedef struct packed
	{
		axi_addr_t addr; // always beat aligned
		axi_len_t  len;
	} ar_req_t;

	// R channel payload, rresp is not used
	typedef struct packed
	{
		axi_data_t data;
		logic      last; // last beat of the burst
	} r_beat_t;

endpackage
